// ==== all.f ====
verilog/aluPkg.sv
verilog/isaPkg.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/programMemory.sv
verilog/controlUnit.sv
verilog/cpuTop.sv
testbench/cpuTopTb.sv

// ==== Makefile ====
# Verilator build and run of the core testbench

VERILATOR ?= verilator
TOP       ?= cpuTopTb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
SIM       ?= Vsim
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(SIM)
	@out="$$(./$(BUILD_DIR)/$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/cpuTopTb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the 8-bit core that loads small programs,
// starts them and checks output port values, flags and cycle counts
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cpuTopTb;

    localparam int addrWidth = 8;
    localparam int numEdge   = 6;
    localparam int numRandom = 4;
    // Longest program is 11 words
    // Budget per program covers loading, the start pulse and the run
    localparam int progCount      = 8 * (numEdge + numRandom) + 3;
    localparam int cyclesPerProg  = 11 + 2 * 11 + 8;
    localparam int watchdogCycles = 10 + progCount * cyclesPerProg + 200;

    // Directed ALU operands for add overflow, X below Y and shifts by 8 and more
    localparam logic [7:0] edgeX [0:numEdge-1] = '{8'hF0, 8'h03, 8'h81, 8'h5A, 8'h00, 8'h96};
    localparam logic [7:0] edgeY [0:numEdge-1] = '{8'h20, 8'h05, 8'h08, 8'hC8, 8'h00, 8'h03};

    logic                          i_clk;
    logic                          i_rst      = 1'b1;
    logic                          i_start    = 1'b0;
    logic                          i_progWe   = 1'b0;
    logic [addrWidth-1:0]          i_progAddr = '0;
    logic [isaPkg::instrWidth-1:0] i_progData = '0;
    logic                          o_busy;
    logic                          o_halted;
    logic                          o_outValid;
    logic [7:0]                    o_outData;
    aluPkg::flagsT                 o_flags;

    int                            seed = 57;
    logic [isaPkg::instrWidth-1:0] progQ [$];
    logic [7:0]                    outQ [$];
    logic [7:0]                    expQ [$];

    cpuTop #(
        .progAddrWidth(addrWidth)
    ) dut (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_start    (i_start),
        .i_progWe   (i_progWe),
        .i_progAddr (i_progAddr),
        .i_progData (i_progData),
        .o_busy     (o_busy),
        .o_halted   (o_halted),
        .o_outValid (o_outValid),
        .o_outData  (o_outData),
        .o_flags    (o_flags)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // Capture the output port on the falling edge
    always @(negedge i_clk) begin
        if (o_outValid) begin
            outQ.push_back(o_outData);
        end
    end

    task automatic abortRun();
        $display("tests failed");
        $fatal(1, "Stopped at the first error");
    endtask

    initial begin
        repeat (watchdogCycles) @(posedge i_clk);
        $display("Timeout: the tests did not finish within %0d clock cycles", watchdogCycles);
        abortRun();
    end

    task automatic checkData(input string name, input logic [7:0] expVal,
                             input logic [7:0] actVal);
        if (actVal !== expVal) begin
            $display("ERR %0t %s expected %h got %h", $time, name, expVal, actVal);
            abortRun();
        end
    endtask

    task automatic checkFlags(input string name, input aluPkg::flagsT expVal,
                              input aluPkg::flagsT actVal);
        if (actVal !== expVal) begin
            $display("ERR %0t %s expected %b got %b", $time, name, expVal, actVal);
            abortRun();
        end
    endtask

    task automatic checkLevel(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            $display("ERR %0t %s expected %b got %b", $time, name, expVal, actVal);
            abortRun();
        end
    endtask

    task automatic checkCount(input string name, input int expVal, input int actVal);
        if (actVal != expVal) begin
            $display("ERR %0t %s expected %0d got %0d", $time, name, expVal, actVal);
            abortRun();
        end
    endtask

    // Instruction word builders following the ISA field layout
    function automatic logic [15:0] ldiWord(input logic [2:0] rd, input logic [7:0] imm);
        return {isaPkg::opLdi, rd, 1'b0, imm};
    endfunction

    function automatic logic [15:0] aluWord(input aluPkg::aluOpT op, input logic [2:0] rd,
                                            input logic [2:0] rx, input logic [2:0] ry);
        return {1'b0, op, rd, rx, ry, 3'b000};
    endfunction

    // Select bit 0 left clear so register X is emitted
    function automatic logic [15:0] outWord(input logic [2:0] rx);
        return {isaPkg::opOut, 3'd0, rx, 6'd0};
    endfunction

    // Select bit 0 set so register Y is emitted while X points at r0
    function automatic logic [15:0] outYWord(input logic [2:0] ry);
        return {isaPkg::opOut, 3'd0, 3'd0, ry, 2'd0, 1'b1};
    endfunction

    function automatic logic [15:0] brzWord(input logic [7:0] target);
        return {isaPkg::opBrz, 4'd0, target};
    endfunction

    function automatic logic [15:0] haltWord();
        return {isaPkg::opHalt, 12'd0};
    endfunction

    // Expected ALU result and flags for one operation
    function automatic void predictAlu(input aluPkg::aluOpT op, input logic [7:0] x,
                                       input logic [7:0] y, output logic [7:0] res,
                                       output aluPkg::flagsT fl);
        logic [8:0] sum;
        sum = {1'b0, x} + {1'b0, y};
        res = 8'd0;
        fl  = '0;
        case (op)
            aluPkg::opAdd: begin
                res = sum[7:0];
                fl[aluPkg::flagCarry] = sum[8];
            end
            aluPkg::opSub: begin
                res = x - y;
                fl[aluPkg::flagNeg] = (x < y);
            end
            aluPkg::opShl: begin
                if (y >= 8'd8) begin
                    fl[aluPkg::flagCarry] = (x != 8'd0);
                end else begin
                    res = x << y;
                    // Bits that leave the top of the byte
                    fl[aluPkg::flagCarry] = (y != 8'd0) && ((x >> (8 - y)) != 8'd0);
                end
            end
            aluPkg::opShr: res = (y >= 8'd8) ? 8'd0 : (x >> y);
            aluPkg::opNot: res = ~x;
            aluPkg::opAnd: res = x & y;
            aluPkg::opOr:  res = x | y;
            default:       res = x ^ y;
        endcase
        fl[aluPkg::flagZero] = (res == 8'd0);
    endfunction

    task automatic loadProgram();
        for (int i = 0; i < progQ.size(); i++) begin
            @(posedge i_clk);
            i_progWe   <= 1'b1;
            i_progAddr <= addrWidth'(i);
            i_progData <= progQ[i];
        end
        @(posedge i_clk);
        i_progWe <= 1'b0;
    endtask

    // Pulse start and count cycles until halt at two per instruction
    task automatic runProgram(input int execCount);
        int cycles;
        outQ.delete();
        @(posedge i_clk);
        i_start <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        cycles = 0;
        @(negedge i_clk);
        while (!o_halted) begin
            checkLevel("o_busy", 1'b1, o_busy);
            if (cycles > 2 * execCount + 4) begin
                $display("Program of %0d instructions did not reach HALT", execCount);
                abortRun();
            end
            @(posedge i_clk);
            cycles++;
            @(negedge i_clk);
        end
        checkLevel("o_busy", 1'b0, o_busy);
        checkCount("cycles from start to halt", 2 * execCount, cycles);
    endtask

    task automatic checkOutputs();
        checkCount("output count", expQ.size(), outQ.size());
        for (int i = 0; i < expQ.size(); i++) begin
            checkData($sformatf("o_outData[%0d]", i), expQ[i], outQ[i]);
        end
    endtask

    task automatic testReset();
        @(negedge i_clk);
        checkLevel("o_busy", 1'b0, o_busy);
        checkLevel("o_halted", 1'b0, o_halted);
        checkLevel("o_outValid", 1'b0, o_outValid);
        checkFlags("o_flags", 3'b000, o_flags);
    endtask

    task automatic testLoadOutput();
        progQ.delete();
        progQ.push_back(ldiWord(3'd0, 8'h11));
        progQ.push_back(ldiWord(3'd5, 8'hA7));
        progQ.push_back(ldiWord(3'd7, 8'h00));
        progQ.push_back(outWord(3'd5));
        progQ.push_back(outWord(3'd0));
        progQ.push_back(outWord(3'd7));
        progQ.push_back(outYWord(3'd5));
        progQ.push_back(haltWord());
        loadProgram();
        runProgram(8);
        expQ = {8'hA7, 8'h11, 8'h00, 8'hA7};
        checkOutputs();
        // LDI leaves the reset flags alone
        checkFlags("o_flags", 3'b000, o_flags);
    endtask

    task automatic aluCase(input aluPkg::aluOpT op, input logic [7:0] x, input logic [7:0] y);
        logic [7:0]    expRes;
        aluPkg::flagsT expFlags;
        predictAlu(op, x, y, expRes, expFlags);
        progQ.delete();
        progQ.push_back(ldiWord(3'd1, x));
        progQ.push_back(ldiWord(3'd2, y));
        progQ.push_back(aluWord(op, 3'd3, 3'd1, 3'd2));
        progQ.push_back(outWord(3'd3));
        progQ.push_back(haltWord());
        loadProgram();
        runProgram(5);
        expQ = {expRes};
        checkOutputs();
        checkFlags("o_flags", expFlags, o_flags);
    endtask

    task automatic testAluOps();
        aluPkg::aluOpT op;
        logic [7:0]    rx;
        logic [7:0]    ry;
        for (int k = 0; k < 8; k++) begin
            op = aluPkg::aluOpT'(k);
            for (int j = 0; j < numEdge; j++) begin
                aluCase(op, edgeX[j], edgeY[j]);
            end
            for (int j = 0; j < numRandom; j++) begin
                rx = 8'($random(seed));
                ry = 8'($random(seed));
                // Some small Y values so shifts keep part of the byte
                if (j < 2) begin
                    ry = ry & 8'h0F;
                end
                aluCase(op, rx, ry);
            end
        end
    endtask

    task automatic testBranch();
        progQ.delete();
        progQ.push_back(ldiWord(3'd1, 8'h3C));
        progQ.push_back(ldiWord(3'd2, 8'h3C));
        progQ.push_back(aluWord(aluPkg::opXor, 3'd3, 3'd1, 3'd2));
        progQ.push_back(brzWord(8'd5));
        progQ.push_back(outWord(3'd1));
        progQ.push_back(outWord(3'd3));
        progQ.push_back(ldiWord(3'd4, 8'h0F));
        progQ.push_back(aluWord(aluPkg::opXor, 3'd5, 3'd1, 3'd4));
        progQ.push_back(brzWord(8'd10));
        progQ.push_back(outWord(3'd5));
        progQ.push_back(haltWord());
        loadProgram();
        // Taken branch skips address 4 so 10 of 11 words execute
        runProgram(10);
        expQ = {8'h00, 8'h3C ^ 8'h0F};
        checkOutputs();
        checkFlags("o_flags", 3'b000, o_flags);
    endtask

    // Registers r1 and r4 still hold the values from the branch program
    task automatic testRestart();
        logic [7:0]    expSum;
        aluPkg::flagsT expFlags;
        predictAlu(aluPkg::opAdd, 8'h3C, 8'h0F, expSum, expFlags);
        progQ.delete();
        progQ.push_back(outWord(3'd4));
        progQ.push_back(outWord(3'd1));
        progQ.push_back(aluWord(aluPkg::opAdd, 3'd6, 3'd1, 3'd4));
        progQ.push_back(outWord(3'd6));
        progQ.push_back(haltWord());
        loadProgram();
        runProgram(5);
        expQ = {8'h0F, 8'h3C, expSum};
        checkOutputs();
        checkFlags("o_flags", expFlags, o_flags);
    endtask

    initial begin
        repeat (10) @(posedge i_clk);
        i_rst <= 1'b0;
        testReset();
        testLoadOutput();
        testAluOps();
        testBranch();
        testRestart();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/cpuTop.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core top level where the host loads a program while idle, then
// pulses i_start and watches the output port and o_halted
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module cpuTop #(
    parameter int progAddrWidth = 8
) (
    input  wire logic                          i_clk,
    input  wire logic                          i_rst,
    input  wire logic                          i_start,
    input  wire logic                          i_progWe,
    input  wire logic [progAddrWidth-1:0]      i_progAddr,
    input  wire logic [isaPkg::instrWidth-1:0] i_progData,
    output logic                               o_busy,
    output logic                               o_halted,
    output logic                               o_outValid,
    output logic [7:0]                         o_outData,
    output aluPkg::flagsT                      o_flags
);

    logic [isaPkg::instrWidth-1:0]  instr;
    logic [progAddrWidth-1:0]       pc;
    logic [isaPkg::regIdxWidth-1:0] rdIdxX;
    logic [isaPkg::regIdxWidth-1:0] rdIdxY;
    logic [7:0]                     rdDataX;
    logic [7:0]                     rdDataY;
    aluPkg::aluOpT                  aluOp;
    logic [7:0]                     aluResult;
    aluPkg::flagsT                  aluFlags;
    logic                           regWe;
    logic [isaPkg::regIdxWidth-1:0] regWrIdx;
    logic [7:0]                     regWrData;

    // Instruction store addressed by the PC
    programMemory #(
        .progAddrWidth(progAddrWidth)
    ) uProgMem (
        .i_clk    (i_clk),
        .i_we     (i_progWe),
        .i_wrAddr (i_progAddr),
        .i_wrData (i_progData),
        .i_rdAddr (pc),
        .o_rdData (instr)
    );

    controlUnit #(
        .progAddrWidth(progAddrWidth)
    ) uCtrl (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (i_start),
        .i_instr     (instr),
        .o_pc        (pc),
        .o_rdIdxX    (rdIdxX),
        .o_rdIdxY    (rdIdxY),
        .i_rdDataX   (rdDataX),
        .i_rdDataY   (rdDataY),
        .o_aluOp     (aluOp),
        .i_aluResult (aluResult),
        .i_aluFlags  (aluFlags),
        .o_regWe     (regWe),
        .o_regWrIdx  (regWrIdx),
        .o_regWrData (regWrData),
        .o_flags     (o_flags),
        .o_busy      (o_busy),
        .o_halted    (o_halted),
        .o_outValid  (o_outValid),
        .o_outData   (o_outData)
    );

    // Operands feed the ALU and the output path together
    registerFile uRegs (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_we      (regWe),
        .i_wrIdx   (regWrIdx),
        .i_wrData  (regWrData),
        .i_rdIdxX  (rdIdxX),
        .i_rdIdxY  (rdIdxY),
        .o_rdDataX (rdDataX),
        .o_rdDataY (rdDataY)
    );

    alu uAlu (
        .i_op     (aluOp),
        .i_rx     (rdDataX),
        .i_ry     (rdDataY),
        .o_result (aluResult),
        .o_flags  (aluFlags)
    );

endmodule

`default_nettype wire

// ==== verilog/controlUnit.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch/execute sequencer with PC, decode, flag register, branch, output
// port and halt, where each instruction takes one fetch and one execute cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module controlUnit #(
    parameter int progAddrWidth = 8
) (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst,
    input  wire logic                           i_start,
    input  wire logic [isaPkg::instrWidth-1:0]  i_instr,
    output logic [progAddrWidth-1:0]            o_pc,
    output logic [isaPkg::regIdxWidth-1:0]      o_rdIdxX,
    output logic [isaPkg::regIdxWidth-1:0]      o_rdIdxY,
    input  wire logic [7:0]                     i_rdDataX,
    input  wire logic [7:0]                     i_rdDataY,
    output aluPkg::aluOpT                       o_aluOp,
    input  wire logic [7:0]                     i_aluResult,
    input  wire aluPkg::flagsT                  i_aluFlags,
    output logic                                o_regWe,
    output logic [isaPkg::regIdxWidth-1:0]      o_regWrIdx,
    output logic [7:0]                          o_regWrData,
    output aluPkg::flagsT                       o_flags,
    output logic                                o_busy,
    output logic                                o_halted,
    output logic                                o_outValid,
    output logic [7:0]                          o_outData
);

    isaPkg::ctrlStateT              state;
    logic [progAddrWidth-1:0]       pc;
    aluPkg::flagsT                  flagsReg;
    logic [isaPkg::opcodeWidth-1:0] opBits;
    isaPkg::opcodeT                 opcode;
    logic [isaPkg::immWidth-1:0]    imm;
    logic                           isAlu;
    logic                           flagWe;
    logic                           doOut;
    logic                           doHalt;
    logic                           doBranch;

    // Instruction fields are valid during execute
    assign opBits = i_instr[isaPkg::opcodeLsb +: isaPkg::opcodeWidth];
    assign opcode = isaPkg::opcodeT'(opBits);
    assign imm    = i_instr[isaPkg::immLsb +: isaPkg::immWidth];
    // Top opcode bit clear means an ALU operation
    assign isAlu  = ~opBits[isaPkg::opcodeWidth-1];

    assign o_rdIdxX   = i_instr[isaPkg::rxLsb +: isaPkg::regIdxWidth];
    assign o_rdIdxY   = i_instr[isaPkg::ryLsb +: isaPkg::regIdxWidth];
    assign o_regWrIdx = i_instr[isaPkg::rdLsb +: isaPkg::regIdxWidth];
    assign o_aluOp    = aluPkg::aluOpT'(opBits[2:0]);
    // LDI writes the immediate and ALU ops write the result
    assign o_regWrData = (opcode == isaPkg::opLdi) ? imm : i_aluResult;

    // Decode with every action gated by the execute cycle
    always_comb begin
        o_regWe  = 1'b0;
        flagWe   = 1'b0;
        doOut    = 1'b0;
        doHalt   = 1'b0;
        doBranch = 1'b0;
        if (state == isaPkg::stExecute) begin
            case (opcode)
                isaPkg::opLdi:  o_regWe = 1'b1;
                isaPkg::opOut:  doOut = 1'b1;
                isaPkg::opBrz:  doBranch = flagsReg[aluPkg::flagZero];
                isaPkg::opHalt: doHalt = 1'b1;
                default: begin
                    // ALU ops write the register and the flags
                    // Codes 12..15 fall through as NOP
                    o_regWe = isAlu;
                    flagWe  = isAlu;
                end
            endcase
        end
    end

    // FSM, PC and flag register
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state      <= isaPkg::stIdle;
            pc         <= '0;
            flagsReg   <= '0;
            o_outValid <= 1'b0;
        end else begin
            // One-cycle pulse after the OUT execute edge
            o_outValid <= doOut;
            case (state)
                isaPkg::stIdle, isaPkg::stHalted: begin
                    if (i_start) begin
                        state <= isaPkg::stFetch;
                        pc    <= '0;
                    end
                end
                isaPkg::stFetch: state <= isaPkg::stExecute;
                isaPkg::stExecute: begin
                    state <= doHalt ? isaPkg::stHalted : isaPkg::stFetch;
                    // Target truncated to the memory depth and the increment wraps
                    if (doBranch) begin
                        pc <= i_instr[isaPkg::immLsb +: progAddrWidth];
                    end else if (!doHalt) begin
                        pc <= pc + 1'b1;
                    end
                    if (flagWe) begin
                        flagsReg <= i_aluFlags;
                    end
                end
                default: state <= isaPkg::stIdle;
            endcase
        end
    end

    // Output payload is register X unless the select bit asks for Y
    always_ff @(posedge i_clk) begin
        if (doOut) begin
            o_outData <= i_instr[isaPkg::outSelPos] ? i_rdDataY : i_rdDataX;
        end
    end

    assign o_pc     = pc;
    assign o_flags  = flagsReg;
    assign o_busy   = (state == isaPkg::stFetch) || (state == isaPkg::stExecute);
    assign o_halted = (state == isaPkg::stHalted);

endmodule

`default_nettype wire

// ==== verilog/programMemory.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction memory written by the host one word per cycle
// The core reads through a registered port with one cycle of latency
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module programMemory #(
    parameter int progAddrWidth = 8
) (
    input  wire logic                         i_clk,
    input  wire logic                         i_we,
    input  wire logic [progAddrWidth-1:0]     i_wrAddr,
    input  wire logic [isaPkg::instrWidth-1:0] i_wrData,
    input  wire logic [progAddrWidth-1:0]     i_rdAddr,
    output logic [isaPkg::instrWidth-1:0]     o_rdData
);

    localparam int depth = 2 ** progAddrWidth;

    logic [isaPkg::instrWidth-1:0] mem [0:depth-1];

    // Host load port
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_wrAddr] <= i_wrData;
        end
    end

    // Fetch port
    always_ff @(posedge i_clk) begin
        o_rdData <= mem[i_rdAddr];
    end

endmodule

`default_nettype wire

// ==== verilog/registerFile.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Eight 8-bit general registers, two asynchronous reads, one
// synchronous write; all registers clear on reset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  wire logic       i_clk,
    input  wire logic       i_rst,
    input  wire logic       i_we,
    input  wire logic [2:0] i_wrIdx,
    input  wire logic [7:0] i_wrData,
    input  wire logic [2:0] i_rdIdxX,
    input  wire logic [2:0] i_rdIdxY,
    output logic [7:0]      o_rdDataX,
    output logic [7:0]      o_rdDataY
);

    logic [7:0] regs [0:7];

    // Write port
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= 8'd0;
            end
        end else if (i_we) begin
            regs[i_wrIdx] <= i_wrData;
        end
    end

    // Read ports see the old value during a write cycle
    assign o_rdDataX = regs[i_rdIdxX];
    assign o_rdDataY = regs[i_rdIdxY];

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational 8-bit ALU with zero, carry and negative flags
// Result and flags settle in the same cycle as the operands
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire aluPkg::aluOpT i_op,
    input  wire logic [7:0]    i_rx,
    input  wire logic [7:0]    i_ry,
    output logic [7:0]         o_result,
    output aluPkg::flagsT      o_flags
);

    // Wide intermediate keeps the carry and shifted-out bits
    logic [15:0] wide;
    logic        shlCarry;

    always_comb begin
        case (i_op)
            aluPkg::opAdd: wide = {8'd0, i_rx} + {8'd0, i_ry};
            aluPkg::opSub: wide = {8'd0, i_rx} - {8'd0, i_ry};
            aluPkg::opShl: wide = {8'd0, i_rx} << i_ry;
            aluPkg::opShr: wide = {8'd0, i_rx} >> i_ry;
            aluPkg::opNot: wide = {8'd0, ~i_rx};
            aluPkg::opAnd: wide = {8'd0, i_rx & i_ry};
            aluPkg::opOr:  wide = {8'd0, i_rx | i_ry};
            aluPkg::opXor: wide = {8'd0, i_rx ^ i_ry};
            default:       wide = 16'd0;
        endcase
    end

    // Shift of 8 or more pushes every set bit past bit 7
    // Large amounts also lose them off the 16-bit value
    always_comb begin
        if (i_ry >= 8'd8) begin
            shlCarry = |i_rx;
        end else begin
            shlCarry = |wide[15:8];
        end
    end

    assign o_result = wide[7:0];

    always_comb begin
        o_flags = '0;
        // Zero on the 8-bit result only
        o_flags[aluPkg::flagZero] = (wide[7:0] == 8'd0);
        // Carry only for add and shift left
        case (i_op)
            aluPkg::opAdd: o_flags[aluPkg::flagCarry] = wide[8];
            aluPkg::opShl: o_flags[aluPkg::flagCarry] = shlCarry;
            default:       o_flags[aluPkg::flagCarry] = 1'b0;
        endcase
        // Negative only when subtract borrows
        o_flags[aluPkg::flagNeg] = (i_op == aluPkg::opSub) && (i_rx < i_ry);
    end

endmodule

`default_nettype wire

// ==== verilog/isaPkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction set of the core with opcodes, field layout of the 16-bit
// instruction word and the control FSM states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package isaPkg;

    // Opcodes 0 to 7 map onto the ALU operations by their low 3 bits
    // Codes 12 to 15 execute as no-operation
    typedef enum logic [3:0] {
        opAdd  = 4'd0,
        opSub  = 4'd1,
        opShl  = 4'd2,
        opShr  = 4'd3,
        opNot  = 4'd4,
        opAnd  = 4'd5,
        opOr   = 4'd6,
        opXor  = 4'd7,
        opLdi  = 4'd8,
        opOut  = 4'd9,
        opBrz  = 4'd10,
        opHalt = 4'd11
    } opcodeT;

    // Instruction word layout as lowest bit plus width
    localparam int instrWidth  = 16;
    localparam int opcodeLsb   = 12;
    localparam int opcodeWidth = 4;
    localparam int rdLsb       = 9;
    localparam int rxLsb       = 6;
    localparam int ryLsb       = 3;
    localparam int regIdxWidth = 3;
    localparam int immLsb      = 0;
    localparam int immWidth    = 8;
    // Set on OUT to emit register Y instead of register X
    localparam int outSelPos   = 0;

    // Control FSM
    typedef enum logic [1:0] {
        stIdle    = 2'd0,
        stFetch   = 2'd1,
        stExecute = 2'd2,
        stHalted  = 2'd3
    } ctrlStateT;

endpackage

`default_nettype wire

// ==== verilog/aluPkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU operation codes and flag layout shared by the datapath, the
// control unit and the testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package aluPkg;

    // Operation select encoded 0 to 7 as the ALU opcode field
    typedef enum logic [2:0] {
        opAdd = 3'd0,
        opSub = 3'd1,
        opShl = 3'd2,
        opShr = 3'd3,
        opNot = 3'd4,
        opAnd = 3'd5,
        opOr  = 3'd6,
        opXor = 3'd7
    } aluOpT;

    // Flag vector with one bit per condition
    typedef logic [2:0] flagsT;

    // Bit positions inside flagsT
    localparam int flagNeg   = 0;
    localparam int flagZero  = 1;
    localparam int flagCarry = 2;

endpackage

`default_nettype wire
